//--- hw/rv_core_params.svh
/*
 * Size macros for the rv_core single-cycle RV32I core.
 * Included by every RTL module that sizes a datapath or a memory.
 */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// datapath
`define RV_XLEN 32        // register and bus width
`define RV_NREGS 32       // architectural registers x0..x31

// instruction memory, word array
`define RV_IMEM_WORDS 256 // depth in words
`define RV_IMEM_AW 8      // word address width

// data memory, word array
`define RV_DMEM_WORDS 256 // depth in words
`define RV_DMEM_AW 8      // word address width, byte addr bits 9:2

`endif

//--- hw/rv_core_pkg.sv
/*
 * Shared types for rv_core: opcodes, ALU operations, operand selects,
 * the instruction field view and the per-instruction control bundle.
 * Modules name these as rv_core_pkg::name in ports, wildcard import inside.
 */
package rv_core_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011  // only ecall is decoded
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_PASS_B              // result = b
  } alu_op_e;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,          // auipc
    A_ZERO = 2'd2           // lui
  } a_sel_e;

  // declared msb first so a cast of the raw word lines up
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } inst_fields_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    b_is_imm;      // operand b is imm, else rs2_data
    a_sel_e  a_sel;
    logic    pc_to_reg;     // write pc+4 (jal, jalr)
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    is_ecall;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

//--- hw/rv_fetch.sv
/*
 * Fetch stage: pc register, next-pc select, halt flag and instruction memory.
 * The imem load port is meant to be used while the core sits in reset.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_fetch (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_core_pkg::ctrl_t    ctrl,
  input  logic                  bcond,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic [`RV_XLEN-1:0]   jalr_target,
  input  logic                  imem_we,
  input  logic [`RV_IMEM_AW-1:0] imem_addr,
  input  logic [31:0]           imem_wdata,
  output logic [`RV_XLEN-1:0]   pc,
  output logic [`RV_XLEN-1:0]   pc_plus4,
  output logic [31:0]           instr,
  output logic                  is_halted
);

  logic [31:0] imem [0:`RV_IMEM_WORDS-1]; // program store, no reset
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] branch_target;
  logic halted_q;                          // sticky once ecall commits

  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign branch_target = pc + imm;         // shared by jal and branches
  assign instr = imem[pc[`RV_IMEM_AW+1:2]]; // word index, async read
  assign is_halted = halted_q | ctrl.is_ecall; // high in the ecall cycle itself

  always_comb begin
    if (is_halted) begin
      next_pc = pc;                        // freeze
    end else if (ctrl.is_jal || (ctrl.is_branch && bcond)) begin
      next_pc = branch_target;
    end else if (ctrl.is_jalr) begin
      next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0}; // bit 0 cleared per spec
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
      halted_q <= 1'b0;
    end else begin
      pc <= next_pc;
      halted_q <= is_halted;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;     // one word per strobe
    end
  end

  // targets come from imm and the ALU, so alignment depends on the program
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

endmodule

//--- hw/rv_decode.sv
/*
 * Decode: splits the instruction word, builds the control bundle and the
 * sign-extended immediate. Purely combinational, feeds fetch, ALU and memory.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_decode (
  output rv_core_pkg::ctrl_t  ctrl,
  input  logic [31:0]         instr,
  output logic [`RV_XLEN-1:0] imm,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd
);
  import rv_core_pkg::*;

  inst_fields_t f;

  // shared by OP and OP-IMM; alt is funct7 bit 5
  function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt,
                                       input logic is_reg);
    case (funct3)
      3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD; // no subi
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign f = inst_fields_t'(instr);
  assign rs1 = f.rs1;
  assign rs2 = f.rs2;
  assign rd = f.rd;

  always_comb begin
    ctrl = '0;                            // unknown opcode: nothing fires
    case (f.opcode)
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = arith_op(f.funct3, f.funct7[5], 1'b1);
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.alu_op = arith_op(f.funct3, f.funct7[5], 1'b0);
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.b_is_imm = 1'b1;             // addr = rs1 + imm
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_is_imm = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.alu_op = ALU_SUB;            // bcond comes from the compare
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.alu_op = ALU_PASS_B;         // result unused
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jalr = 1'b1;
        ctrl.b_is_imm = 1'b1;             // target = rs1 + imm
      end
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.a_sel = A_ZERO;              // 0 + imm
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm = 1'b1;
        ctrl.a_sel = A_PC;
      end
      OP_SYSTEM: ctrl.is_ecall = 1'b1;    // treated as halt
      default: ;
    endcase
  end

  always_comb begin
    case (f.opcode)
      OP_IMM, OP_LOAD, OP_JALR: imm = {{20{instr[31]}}, instr[31:20]};
      OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
      OP_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:   imm = '0;
    endcase
  end

endmodule

//--- hw/rv_alu.sv
/*
 * Integer ALU and branch compare. result follows alu_op, bcond follows
 * funct3 of a branch and is ignored for every other instruction.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e alu_op,
  input  logic [2:0]           funct3,
  input  logic [`RV_XLEN-1:0]  a,
  input  logic [`RV_XLEN-1:0]  b,
  output logic [`RV_XLEN-1:0]  result,
  output logic                 bcond
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic lt_s;
  logic lt_u;

  assign shamt = b[4:0];                  // rv32 shifts use 5 bits
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt; // sign fill
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  bcond = (a == b);          // beq
      3'b001:  bcond = (a != b);          // bne
      3'b100:  bcond = lt_s;              // blt
      3'b101:  bcond = !lt_s;             // bge
      3'b110:  bcond = lt_u;              // bltu
      3'b111:  bcond = !lt_u;             // bgeu
      default: bcond = 1'b0;
    endcase
  end

endmodule

//--- hw/rv_regfile.sv
/*
 * 32 x XLEN register file: two operand read ports, one debug read port
 * and one write port. Reads are combinational, x0 is hardwired zero.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [4:0]          rd,
  input  logic [4:0]          dbg_addr,
  input  logic [`RV_XLEN-1:0] rd_data,
  input  logic                we,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] dbg_data
);

  logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
  assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr]; // testbench view

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;              // x0 writes dropped
    end
  end

endmodule

//--- hw/rv_dmem.sv
/*
 * Word data memory for lw and sw. Write on the clock edge, read is
 * combinational and returns zero unless mem_read is set.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_dmem (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic                mem_read,
  input  logic                mem_write,
  output logic [`RV_XLEN-1:0] rdata
);

  logic [`RV_XLEN-1:0] mem [0:`RV_DMEM_WORDS-1];
  logic [`RV_DMEM_AW-1:0] widx;

  assign widx = addr[`RV_DMEM_AW+1:2];    // byte addr to word index
  assign rdata = mem_read ? mem[widx] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        mem[i] <= '0;                   // known contents for loads
      end
    end else if (mem_write) begin
      mem[widx] <= wdata;
    end
  end

  // only lw and sw exist, so low address bits must be zero
  a_word_access: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_read || mem_write) |-> addr[1:0] == 2'b00)
    else $error("unaligned data access at %h", addr);

endmodule

//--- hw/rv_core.sv
/*
 * rv_core top: single-cycle RV32I core. Load a program through the imem port
 * with rst_n low, release reset and wait for is_halted. Registers are read
 * back over the debug port.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   imem_we,
  input  logic [`RV_IMEM_AW-1:0] imem_addr,
  input  logic [31:0]            imem_wdata,
  input  logic [4:0]             dbg_addr,
  output logic [`RV_XLEN-1:0]    dbg_data,
  output logic                   is_halted
);
  import rv_core_pkg::*;

  ctrl_t ctrl;
  logic [31:0] instr;
  logic [`RV_XLEN-1:0] pc, pc_plus4, imm;
  logic [`RV_XLEN-1:0] rs1_data, rs2_data;
  logic [`RV_XLEN-1:0] alu_a, alu_b, result;
  logic [`RV_XLEN-1:0] mem_rdata, wb_data;
  logic [4:0] rs1, rs2, rd;
  logic bcond;
  logic reg_we, mem_we;

  assign reg_we = ctrl.reg_write && !is_halted; // nothing commits once halted
  assign mem_we = ctrl.mem_write && !is_halted;

  always_comb begin
    case (ctrl.a_sel)
      A_PC:    alu_a = pc;
      A_ZERO:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end
  assign alu_b = ctrl.b_is_imm ? imm : rs2_data;

  // link address wins, then load data, then ALU
  assign wb_data = ctrl.pc_to_reg ? pc_plus4 : (ctrl.mem_to_reg ? mem_rdata : result);

  rv_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .bcond(bcond), .imm(imm),
    .jalr_target(result),               // rs1 + imm from the ALU
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .pc(pc), .pc_plus4(pc_plus4), .instr(instr), .is_halted(is_halted)
  );

  rv_decode u_decode (
    .instr(instr), .ctrl(ctrl), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
    .dbg_addr(dbg_addr), .rd_data(wb_data), .we(reg_we),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .dbg_data(dbg_data)
  );

  rv_alu u_alu (
    .alu_op(ctrl.alu_op), .funct3(instr[14:12]), .a(alu_a), .b(alu_b),
    .result(result), .bcond(bcond)
  );

  rv_dmem u_dmem (
    .clk(clk), .rst_n(rst_n), .addr(result), .wdata(rs2_data),
    .mem_read(ctrl.mem_read), .mem_write(mem_we), .rdata(mem_rdata)
  );

endmodule

//--- verif/rv_asm.svh
/*
 * RV32I instruction encoders for assembling test programs, plus the
 * Fibonacci LFSR step behind the random operands. Included inside rv_core_tb.
 */
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

localparam logic [6:0] op_reg = 7'b0110011;
localparam logic [6:0] op_imm = 7'b0010011;
localparam logic [6:0] op_load = 7'b0000011;
localparam logic [6:0] op_jalr = 7'b1100111;
localparam logic [6:0] op_lui = 7'b0110111;
localparam logic [6:0] op_auipc = 7'b0010111;
localparam logic [31:0] ecall_insn = 32'h00000073; // halts the core

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rs1, f3, rd, op};      // op-imm, load, jalr
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw only
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rd, op};               // lui, auipc
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// x^32 + x^22 + x^2 + x + 1, shifts left, new bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

//--- verif/rv_core_tb.sv
/*
 * Directed testbench for rv_core. Each test assembles a short program,
 * loads it through the imem port under reset, runs to ecall and reads
 * the registers back over the debug port.
 */
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core_tb;

  typedef struct packed {
    logic [2:0] f3;
    logic [4:0] t_rs1;                  // operand pair that takes the branch
    logic [4:0] t_rs2;
    logic [4:0] n_rs1;                  // pair that falls through
    logic [4:0] n_rs2;
  } branch_case_t;

  logic clk;
  logic rst_n;
  logic imem_we;
  logic [`RV_IMEM_AW-1:0] imem_addr;
  logic [31:0] imem_wdata;
  logic [4:0] dbg_addr;
  logic [31:0] dbg_data;
  logic is_halted;

  logic [31:0] prog [$];                // program under assembly
  logic [31:0] lfsr_state;
  string test_name;
  int errors;
  int checks;

  `include "rv_asm.svh"

  rv_core dut0 (
    .clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .dbg_addr(dbg_addr), .dbg_data(dbg_data),
    .is_halted(is_halted)
  );

  always #5 clk = ~clk;                 // 10 ns period

  function automatic void emit(input logic [31:0] w);
    prog.push_back(w);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // lui + addi, upper part rounded for the sign of the low 12 bits
  function automatic void load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(u_type(hi[31:12], rd, op_lui));
    emit(i_type(v[11:0], rd, 3'b000, rd, op_imm));
  endfunction

  task automatic load_program();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    foreach (prog[i]) begin
      @(posedge clk);
      #1;
      imem_we = 1'b1;
      imem_addr = `RV_IMEM_AW'(i);
      imem_wdata = prog[i];
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    rst_n = 1'b1;                       // pc 0 runs on the next edge
  endtask

  task automatic run_until_halt();
    int cyc;
    cyc = 0;
    while (!is_halted && cyc < 2000) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (!is_halted) begin
      errors++;
      $display("%s: program never halted within 2000 cycles (time %0t ns)", test_name, $time);
    end
  endtask

  task automatic check_reg(input logic [4:0] idx, input logic [31:0] exp);
    @(posedge clk);
    #1;
    dbg_addr = idx;
    #1;                                 // debug read is combinational
    checks++;
    if (dbg_data !== exp) begin
      errors++;
      $display("error at %0t ns: %s x%0d expected %h got %h",
               $time, test_name, idx, exp, dbg_data);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t ns: %s %s expected %b got %b", $time, test_name, what, exp, act);
    end
  endtask

  task automatic arith_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [11:0] imm;
    logic [4:0] sh;
    test_name = "arith";
    prog.delete();
    a = rand_bits(32);
    b = rand_bits(32);
    imm = 12'(rand_bits(12));
    sh = 5'(rand_bits(5));
    sx = {{20{imm[11]}}, imm};          // I-type sign extension
    load_const(1, a);
    load_const(2, b);
    emit(r_type(7'h00, 2, 1, 3'b000, 3)); // add
    emit(r_type(7'h20, 2, 1, 3'b000, 4)); // sub
    emit(r_type(7'h00, 2, 1, 3'b111, 5)); // and
    emit(r_type(7'h00, 2, 1, 3'b110, 6)); // or
    emit(r_type(7'h00, 2, 1, 3'b100, 7)); // xor
    emit(r_type(7'h00, 2, 1, 3'b001, 8)); // sll
    emit(r_type(7'h00, 2, 1, 3'b101, 9)); // srl
    emit(r_type(7'h20, 2, 1, 3'b101, 10)); // sra
    emit(r_type(7'h00, 2, 1, 3'b010, 11)); // slt
    emit(r_type(7'h00, 2, 1, 3'b011, 12)); // sltu
    emit(i_type(imm, 1, 3'b000, 13, op_imm)); // addi
    emit(i_type(imm, 1, 3'b010, 14, op_imm)); // slti
    emit(i_type(imm, 1, 3'b011, 15, op_imm)); // sltiu
    emit(i_type(imm, 1, 3'b100, 16, op_imm)); // xori
    emit(i_type(imm, 1, 3'b110, 17, op_imm)); // ori
    emit(i_type(imm, 1, 3'b111, 18, op_imm)); // andi
    emit(i_type({7'h00, sh}, 1, 3'b001, 19, op_imm)); // slli
    emit(i_type({7'h00, sh}, 1, 3'b101, 20, op_imm)); // srli
    emit(i_type({7'h20, sh}, 1, 3'b101, 21, op_imm)); // srai
    emit(ecall_insn);
    load_program();
    run_until_halt();
    check_reg(3, a + b);
    check_reg(4, a - b);
    check_reg(5, a & b);
    check_reg(6, a | b);
    check_reg(7, a ^ b);
    check_reg(8, a << b[4:0]);
    check_reg(9, a >> b[4:0]);
    check_reg(10, $signed(a) >>> b[4:0]);
    check_reg(11, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    check_reg(12, (a < b) ? 32'd1 : 32'd0);
    check_reg(13, a + sx);
    check_reg(14, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
    check_reg(15, (a < sx) ? 32'd1 : 32'd0);
    check_reg(16, a ^ sx);
    check_reg(17, a | sx);
    check_reg(18, a & sx);
    check_reg(19, a << sh);
    check_reg(20, a >> sh);
    check_reg(21, $signed(a) >>> sh);
  endtask

  task automatic memory_test();
    logic [31:0] vals [4];
    logic [11:0] offs [4];
    test_name = "memory";
    prog.delete();
    offs = '{12'h000, 12'h004, 12'hffc, 12'h040}; // one negative offset
    emit(i_type(12'h100, 0, 3'b000, 1, op_imm)); // base 0x100
    for (int i = 0; i < 4; i++) begin
      vals[i] = rand_bits(32);
      load_const(5'(2 + i), vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      emit(s_type(offs[i], 5'(2 + i), 1));
    end
    for (int i = 3; i >= 0; i--) begin
      emit(i_type(offs[i], 1, 3'b010, 5'(6 + i), op_load)); // reverse order
    end
    emit(ecall_insn);
    load_program();
    run_until_halt();
    for (int i = 0; i < 4; i++) begin
      check_reg(5'(6 + i), vals[i]);
    end
  endtask

  task automatic branch_test();
    branch_case_t cases [6];
    test_name = "branch";
    prog.delete();
    cases[0] = '{3'b000, 5'd1, 5'd2, 5'd1, 5'd4}; // beq 5==5, 5!=7
    cases[1] = '{3'b001, 5'd1, 5'd4, 5'd1, 5'd2}; // bne
    cases[2] = '{3'b100, 5'd3, 5'd1, 5'd1, 5'd3}; // blt -3<5
    cases[3] = '{3'b101, 5'd1, 5'd3, 5'd3, 5'd1}; // bge
    cases[4] = '{3'b110, 5'd1, 5'd3, 5'd3, 5'd1}; // bltu 5 < 0xfffffffd
    cases[5] = '{3'b111, 5'd3, 5'd1, 5'd1, 5'd3}; // bgeu
    emit(i_type(12'd5, 0, 3'b000, 1, op_imm));
    emit(i_type(12'd5, 0, 3'b000, 2, op_imm));
    emit(i_type(12'hffd, 0, 3'b000, 3, op_imm)); // -3
    emit(i_type(12'd7, 0, 3'b000, 4, op_imm));
    for (int i = 0; i < 6; i++) begin
      emit(b_type(13'd8, cases[i].t_rs2, cases[i].t_rs1, cases[i].f3));
      emit(i_type(12'd1, 0, 3'b000, 5'(10 + 2 * i), op_imm)); // skipped marker
      emit(b_type(13'd8, cases[i].n_rs2, cases[i].n_rs1, cases[i].f3));
      emit(i_type(12'd1, 0, 3'b000, 5'(11 + 2 * i), op_imm)); // executed marker
    end
    emit(ecall_insn);
    load_program();
    run_until_halt();
    for (int i = 0; i < 6; i++) begin
      check_reg(5'(10 + 2 * i), 32'd0);
      check_reg(5'(11 + 2 * i), 32'd1);
    end
  endtask

  task automatic jump_test();
    test_name = "jump";
    prog.delete();
    emit(j_type(21'd12, 5));            // pc 0: jal x5 -> 12
    emit(i_type(12'd1, 0, 3'b000, 6, op_imm));
    emit(i_type(12'd2, 0, 3'b000, 6, op_imm));
    emit(i_type(12'd29, 0, 3'b000, 7, op_imm)); // pc 12
    emit(i_type(12'd4, 7, 3'b000, 8, op_jalr)); // pc 16: 29+4=33, lands at 32
    emit(i_type(12'd1, 0, 3'b000, 9, op_imm));
    emit(i_type(12'd2, 0, 3'b000, 9, op_imm));
    emit(i_type(12'd3, 0, 3'b000, 9, op_imm));
    emit(u_type(20'h00000, 10, op_auipc)); // pc 32: auipc records the landing pc
    emit(j_type(21'd8, 0));             // pc 36: jal x0 -> 44
    emit(i_type(12'd1, 0, 3'b000, 11, op_imm));
    emit(ecall_insn);                   // pc 44
    load_program();
    run_until_halt();
    check_reg(5, 32'd4);                // link of jal at 0
    check_reg(6, 32'd0);
    check_reg(7, 32'd29);
    check_reg(8, 32'd20);               // link of jalr at 16
    check_reg(9, 32'd0);
    check_reg(10, 32'd32);              // landing pc, bit 0 dropped
    check_reg(11, 32'd0);
  endtask

  task automatic upper_test();
    logic [19:0] u1;
    logic [19:0] u2;
    test_name = "upper";
    prog.delete();
    u1 = 20'(rand_bits(20));
    u2 = 20'(rand_bits(20));
    emit(u_type(u1, 1, op_lui));        // pc 0
    emit(u_type(u2, 2, op_auipc));      // pc 4
    emit(u_type(20'h80000, 3, op_auipc)); // pc 8
    emit(i_type(12'd123, 0, 3'b000, 0, op_imm)); // writes to x0 are dropped
    emit(u_type(u1, 0, op_lui));
    emit(i_type(12'd5, 0, 3'b000, 4, op_imm)); // x0 as operand
    emit(ecall_insn);
    load_program();
    run_until_halt();
    check_reg(1, {u1, 12'h000});
    check_reg(2, 32'd4 + {u2, 12'h000});
    check_reg(3, 32'h8000_0008);
    check_reg(0, 32'd0);
    check_reg(4, 32'd5);
  endtask

  task automatic halt_test();
    test_name = "halt";
    prog.delete();
    emit(i_type(12'd11, 0, 3'b000, 1, op_imm));
    emit(i_type(12'd22, 0, 3'b000, 2, op_imm));
    emit(ecall_insn);
    emit(i_type(12'd99, 0, 3'b000, 1, op_imm)); // never commits
    emit(i_type(12'd1, 0, 3'b000, 3, op_imm));
    emit(u_type(20'h00001, 4, op_lui));
    load_program();
    #1;
    check_flag("is_halted after reset", 1'b0, is_halted);
    run_until_halt();
    check_flag("is_halted after ecall", 1'b1, is_halted);
    repeat (20) @(posedge clk);
    #1;
    check_flag("is_halted 20 cycles on", 1'b1, is_halted);
    check_reg(1, 32'd11);
    check_reg(2, 32'd22);
    check_reg(3, 32'd0);
    check_reg(4, 32'd0);
    @(posedge clk);
    #1;
    rst_n = 1'b0;                       // async reset clears halt and regs
    #1;
    check_flag("is_halted in reset", 1'b0, is_halted);
    check_reg(1, 32'd0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    dbg_addr = '0;
    errors = 0;
    checks = 0;
    lfsr_state = 32'hc01c6050;
    arith_test();
    memory_test();
    branch_test();
    jump_test();
    upper_test();
    halt_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+hw
+incdir+verif
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_dmem.sv
hw/rv_core.sv
verif/rv_core_tb.sv
